// ==== Makefile ====
TOP := soc_fabric_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

obj_dir/V$(TOP): build.f source/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

// ==== build.f ====
source/soc_fabric_pkg.sv
source/axil_req_front.sv
source/req_fifo.sv
source/periph_target.sv
source/soc_fabric_top.sv
verif/soc_fabric_checker.sv
verif/soc_fabric_tb.sv

// ==== source/axil_req_front.sv ====
`timescale 1ns/100ps

module axil_req_front
(
    // Clock and reset
     input  logic                                clk_i
    ,input  logic                                rst_n_i

    // Write address and data
    ,input  logic                                s_awvalid_i
    ,input  logic [soc_fabric_pkg::ADDR_W-1:0]   s_awaddr_i
    ,output logic                                s_awready_o
    ,input  logic                                s_wvalid_i
    ,input  logic [soc_fabric_pkg::DATA_W-1:0]   s_wdata_i
    ,input  logic [soc_fabric_pkg::STRB_W-1:0]   s_wstrb_i
    ,output logic                                s_wready_o

    // Write response
    ,output logic                                s_bvalid_o
    ,output logic [1:0]                          s_bresp_o
    ,input  logic                                s_bready_i

    // Read address and data
    ,input  logic                                s_arvalid_i
    ,input  logic [soc_fabric_pkg::ADDR_W-1:0]   s_araddr_i
    ,output logic                                s_arready_o
    ,output logic                                s_rvalid_o
    ,output logic [soc_fabric_pkg::DATA_W-1:0]   s_rdata_o
    ,output logic [1:0]                          s_rresp_o
    ,input  logic                                s_rready_i

    // Request and response streams
    ,output logic                                req_valid_o
    ,output soc_fabric_pkg::req_t                req_o
    ,input  logic                                req_ready_i
    ,input  logic                                resp_valid_i
    ,input  soc_fabric_pkg::resp_t               resp_i
    ,output logic                                resp_ready_o
);

logic live_q;
logic wr_req_w;
logic wr_accept_w;
logic rd_accept_w;

// Not accepting anything until the cycle after reset
always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        live_q <= 1'b0;
    end else begin
        live_q <= 1'b1;
    end
end

//----------------------------------------------------------------------
// Request side, writes win over reads
//----------------------------------------------------------------------
assign wr_req_w    = live_q & s_awvalid_i & s_wvalid_i;
assign wr_accept_w = wr_req_w & req_ready_i;
assign rd_accept_w = live_q & s_arvalid_i & req_ready_i & ~wr_accept_w;

assign s_awready_o = wr_accept_w;
assign s_wready_o  = wr_accept_w;
assign s_arready_o = rd_accept_w;

assign req_valid_o = wr_req_w | (live_q & s_arvalid_i);

always_comb begin
    req_o.is_write = wr_req_w;
    req_o.addr     = wr_req_w ? s_awaddr_i : s_araddr_i;
    req_o.wdata    = s_wdata_i;
    req_o.wstrb    = wr_req_w ? s_wstrb_i : '0;
end

//----------------------------------------------------------------------
// Response side
//----------------------------------------------------------------------
assign s_bvalid_o = resp_valid_i & resp_i.is_write;
assign s_bresp_o  = resp_i.resp;

assign s_rvalid_o = resp_valid_i & ~resp_i.is_write;
assign s_rdata_o  = resp_i.data;
assign s_rresp_o  = resp_i.resp;

// Ready from whichever channel owns the pending response
assign resp_ready_o = resp_i.is_write ? s_bready_i : s_rready_i;

endmodule

// ==== source/periph_target.sv ====
`timescale 1ns/100ps

module periph_target
#(
     parameter int RAM_WORDS = 256
)
(
     input  logic                                clk_i
    ,input  logic                                rst_n_i
    ,input  logic                                head_valid_i
    ,input  soc_fabric_pkg::req_t                head_req_i
    ,output logic                                head_pop_o
    ,output logic                                resp_valid_o
    ,output soc_fabric_pkg::resp_t               resp_o
    ,input  logic                                resp_ready_i
    ,input  logic [soc_fabric_pkg::DATA_W-1:0]   gpio_input_i
    ,output logic [soc_fabric_pkg::DATA_W-1:0]   gpio_output_o
    ,output logic [soc_fabric_pkg::DATA_W-1:0]   gpio_output_enable_o
    ,output logic                                rst_cpu_o
);

localparam int DW     = soc_fabric_pkg::DATA_W;
localparam int SW     = soc_fabric_pkg::STRB_W;
localparam int RAM_AW = $clog2(RAM_WORDS);

logic [DW-1:0]     ram_q [RAM_WORDS];
logic [DW-1:0]     ram_rdata_q;
logic [25:0]       ram_word_w;
logic [RAM_AW-1:0] ram_idx_w;
logic              hit_ram_w;
logic              hit_reg_w;
logic [3:0]        reg_off_w;
logic [DW-1:0]     reg_rdata_w;
logic              take_w;
logic [DW-1:0]     gpio_out_q;
logic [DW-1:0]     gpio_oe_q;
logic [DW-1:0]     ctrl_q;
logic [DW-1:0]     gpio_in_meta_q;
logic [DW-1:0]     gpio_in_sync_q;
logic              pend_q;
logic              pend_write_q;
logic              pend_err_q;
logic              pend_ram_q;
logic [DW-1:0]     reg_rdata_q;
logic              resp_valid_q;
soc_fabric_pkg::resp_t resp_q;

function automatic logic [DW-1:0] apply_strb(
    input logic [DW-1:0] old_v,
    input logic [DW-1:0] new_v,
    input logic [SW-1:0] strb
);
    logic [DW-1:0] res;
    res = old_v;
    for (int b = 0; b < SW; b++) begin
        if (strb[b]) begin
            res[8*b +: 8] = new_v[8*b +: 8];
        end
    end
    return res;
endfunction

//----------------------------------------------------------------------
// Decode
//----------------------------------------------------------------------
assign hit_ram_w = (head_req_i.addr & soc_fabric_pkg::REGION_MASK) == soc_fabric_pkg::RAM_BASE;
assign hit_reg_w = (head_req_i.addr & soc_fabric_pkg::REGION_MASK) == soc_fabric_pkg::GPIO_BASE;

assign ram_word_w = head_req_i.addr.ram.word % 26'(RAM_WORDS);
assign ram_idx_w  = ram_word_w[RAM_AW-1:0];
assign reg_off_w  = {head_req_i.addr.regs.reg_sel, 2'b00};

// One request in flight, next head waits for the response to leave
assign take_w     = head_valid_i & ~pend_q & ~resp_valid_q;
assign head_pop_o = take_w;

always_ff @(posedge clk_i) begin
    if (take_w) begin
        if (head_req_i.is_write && hit_ram_w) begin
            for (int b = 0; b < SW; b++) begin
                if (head_req_i.wstrb[b]) begin
                    ram_q[ram_idx_w][8*b +: 8] <= head_req_i.wdata[8*b +: 8];
                end
            end
        end
        ram_rdata_q <= ram_q[ram_idx_w];
    end
end

//----------------------------------------------------------------------
// GPIO and control registers
//----------------------------------------------------------------------
always_ff @(posedge clk_i) begin
    gpio_in_meta_q <= gpio_input_i;
    gpio_in_sync_q <= gpio_in_meta_q;
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        gpio_out_q <= '0;
        gpio_oe_q  <= '0;
        ctrl_q     <= '0;
    end else if (take_w && head_req_i.is_write && hit_reg_w) begin
        case (reg_off_w)
            soc_fabric_pkg::REG_GPIO_OUT:
                gpio_out_q <= apply_strb(gpio_out_q, head_req_i.wdata, head_req_i.wstrb);
            soc_fabric_pkg::REG_GPIO_OE:
                gpio_oe_q <= apply_strb(gpio_oe_q, head_req_i.wdata, head_req_i.wstrb);
            soc_fabric_pkg::REG_CTRL:
                ctrl_q <= apply_strb(ctrl_q, head_req_i.wdata, head_req_i.wstrb);
            // Input register drops writes
            default: ;
        endcase
    end
end

always_comb begin
    case (reg_off_w)
        soc_fabric_pkg::REG_GPIO_OUT: reg_rdata_w = gpio_out_q;
        soc_fabric_pkg::REG_GPIO_OE:  reg_rdata_w = gpio_oe_q;
        soc_fabric_pkg::REG_GPIO_IN:  reg_rdata_w = gpio_in_sync_q;
        soc_fabric_pkg::REG_CTRL:     reg_rdata_w = ctrl_q;
        default:                      reg_rdata_w = '0;
    endcase
end

//----------------------------------------------------------------------
// Response pipeline
//----------------------------------------------------------------------
always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        pend_q       <= 1'b0;
        resp_valid_q <= 1'b0;
    end else begin
        pend_q <= take_w;
        if (pend_q) begin
            resp_valid_q <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_q <= 1'b0;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (take_w) begin
        pend_write_q <= head_req_i.is_write;
        pend_err_q   <= ~(hit_ram_w | hit_reg_w);
        pend_ram_q   <= hit_ram_w;
        reg_rdata_q  <= reg_rdata_w;
    end
    // RAM data lands one cycle after take
    if (pend_q) begin
        resp_q.is_write <= pend_write_q;
        resp_q.resp     <= pend_err_q ? soc_fabric_pkg::RESP_SLVERR : soc_fabric_pkg::RESP_OKAY;
        if (pend_err_q || pend_write_q) begin
            resp_q.data <= '0;
        end else begin
            resp_q.data <= pend_ram_q ? ram_rdata_q : reg_rdata_q;
        end
    end
end

assign resp_valid_o = resp_valid_q;
assign resp_o       = resp_q;

assign gpio_output_o        = gpio_out_q;
assign gpio_output_enable_o = gpio_oe_q;
assign rst_cpu_o            = ~ctrl_q[0];

endmodule

// ==== source/req_fifo.sv ====
`timescale 1ns/100ps

module req_fifo
#(
     parameter int FIFO_DEPTH = 4
)
(
     input  logic                    clk_i
    ,input  logic                    rst_n_i
    ,input  logic                    push_i
    ,input  soc_fabric_pkg::req_t    push_req_i
    ,output logic                    full_o
    ,input  logic                    pop_i
    ,output logic                    head_valid_o
    ,output soc_fabric_pkg::req_t    head_req_o
);

localparam int IDX_W = $clog2(FIFO_DEPTH);

soc_fabric_pkg::req_t mem_q [FIFO_DEPTH];

// Extra top bit tells full from empty
logic [IDX_W:0] wr_ptr_q;
logic [IDX_W:0] rd_ptr_q;
logic           empty_w;

assign empty_w = (wr_ptr_q == rd_ptr_q);
assign full_o  = (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]) &&
                 (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]);

assign head_valid_o = ~empty_w;
assign head_req_o   = mem_q[rd_ptr_q[IDX_W-1:0]];

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
    end else begin
        if (push_i) begin
            wr_ptr_q <= wr_ptr_q + (IDX_W+1)'(1);
        end
        if (pop_i && !empty_w) begin
            rd_ptr_q <= rd_ptr_q + (IDX_W+1)'(1);
        end
    end
end

always_ff @(posedge clk_i) begin
    if (push_i) begin
        mem_q[wr_ptr_q[IDX_W-1:0]] <= push_req_i;
    end
end

endmodule

// ==== source/soc_fabric_pkg.sv ====
package soc_fabric_pkg;

    //----------------------------------------------------------------------
    // Bus widths
    //----------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    //----------------------------------------------------------------------
    // Memory map
    //----------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] RAM_BASE    = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] GPIO_BASE   = 32'hF000_0000;
    localparam logic [ADDR_W-1:0] REGION_MASK = 32'hF000_0000;

    // Register offsets within the GPIO region
    localparam logic [3:0] REG_GPIO_OUT = 4'h0;
    localparam logic [3:0] REG_GPIO_OE  = 4'h4;
    localparam logic [3:0] REG_GPIO_IN  = 4'h8;
    localparam logic [3:0] REG_CTRL     = 4'hC;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    //----------------------------------------------------------------------
    // Address views
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [3:0]  region;
        logic [25:0] word;
        logic [1:0]  byte_off;
    } ram_view_t;

    typedef struct packed {
        logic [3:0]  region;
        logic [23:0] unused;
        logic [1:0]  reg_sel;
        logic [1:0]  byte_off;
    } reg_view_t;

    // Same address word, decoded per target
    typedef union packed {
        ram_view_t ram;
        reg_view_t regs;
    } addr_u;

    typedef struct packed {
        logic              is_write;
        addr_u             addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } req_t;

    typedef struct packed {
        logic              is_write;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } resp_t;

endpackage

// ==== source/soc_fabric_top.sv ====
`timescale 1ns/100ps

module soc_fabric_top
//----------------------------------------------------------------------
// Params
//----------------------------------------------------------------------
#(
     parameter int FIFO_DEPTH = 4
    ,parameter int RAM_WORDS  = 256
)
//----------------------------------------------------------------------
// Ports
//----------------------------------------------------------------------
(
     input  logic                                clk_i
    ,input  logic                                rst_n_i
    ,input  logic                                s_awvalid_i
    ,input  logic [soc_fabric_pkg::ADDR_W-1:0]   s_awaddr_i
    ,output logic                                s_awready_o
    ,input  logic                                s_wvalid_i
    ,input  logic [soc_fabric_pkg::DATA_W-1:0]   s_wdata_i
    ,input  logic [soc_fabric_pkg::STRB_W-1:0]   s_wstrb_i
    ,output logic                                s_wready_o
    ,output logic                                s_bvalid_o
    ,output logic [1:0]                          s_bresp_o
    ,input  logic                                s_bready_i
    ,input  logic                                s_arvalid_i
    ,input  logic [soc_fabric_pkg::ADDR_W-1:0]   s_araddr_i
    ,output logic                                s_arready_o
    ,output logic                                s_rvalid_o
    ,output logic [soc_fabric_pkg::DATA_W-1:0]   s_rdata_o
    ,output logic [1:0]                          s_rresp_o
    ,input  logic                                s_rready_i
    ,input  logic [soc_fabric_pkg::DATA_W-1:0]   gpio_input_i
    ,output logic [soc_fabric_pkg::DATA_W-1:0]   gpio_output_o
    ,output logic [soc_fabric_pkg::DATA_W-1:0]   gpio_output_enable_o
    ,output logic                                rst_cpu_o
);

logic                  front_req_valid_w;
soc_fabric_pkg::req_t  front_req_w;
logic                  fifo_full_w;
logic                  fifo_ready_w;
logic                  fifo_push_w;
logic                  head_valid_w;
soc_fabric_pkg::req_t  head_req_w;
logic                  head_pop_w;
logic                  resp_valid_w;
soc_fabric_pkg::resp_t resp_w;
logic                  resp_ready_w;

assign fifo_ready_w = ~fifo_full_w;
assign fifo_push_w  = front_req_valid_w & ~fifo_full_w;

axil_req_front
u_front
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.s_awvalid_i(s_awvalid_i)
    ,.s_awaddr_i(s_awaddr_i)
    ,.s_awready_o(s_awready_o)
    ,.s_wvalid_i(s_wvalid_i)
    ,.s_wdata_i(s_wdata_i)
    ,.s_wstrb_i(s_wstrb_i)
    ,.s_wready_o(s_wready_o)
    ,.s_bvalid_o(s_bvalid_o)
    ,.s_bresp_o(s_bresp_o)
    ,.s_bready_i(s_bready_i)
    ,.s_arvalid_i(s_arvalid_i)
    ,.s_araddr_i(s_araddr_i)
    ,.s_arready_o(s_arready_o)
    ,.s_rvalid_o(s_rvalid_o)
    ,.s_rdata_o(s_rdata_o)
    ,.s_rresp_o(s_rresp_o)
    ,.s_rready_i(s_rready_i)
    ,.req_valid_o(front_req_valid_w)
    ,.req_o(front_req_w)
    ,.req_ready_i(fifo_ready_w)
    ,.resp_valid_i(resp_valid_w)
    ,.resp_i(resp_w)
    ,.resp_ready_o(resp_ready_w)
);

req_fifo
#(
     .FIFO_DEPTH(FIFO_DEPTH)
)
u_fifo
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.push_i(fifo_push_w)
    ,.push_req_i(front_req_w)
    ,.full_o(fifo_full_w)
    ,.pop_i(head_pop_w)
    ,.head_valid_o(head_valid_w)
    ,.head_req_o(head_req_w)
);

periph_target
#(
     .RAM_WORDS(RAM_WORDS)
)
u_target
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.head_valid_i(head_valid_w)
    ,.head_req_i(head_req_w)
    ,.head_pop_o(head_pop_w)
    ,.resp_valid_o(resp_valid_w)
    ,.resp_o(resp_w)
    ,.resp_ready_i(resp_ready_w)
    ,.gpio_input_i(gpio_input_i)
    ,.gpio_output_o(gpio_output_o)
    ,.gpio_output_enable_o(gpio_output_enable_o)
    ,.rst_cpu_o(rst_cpu_o)
);

endmodule

// ==== verif/soc_fabric_checker.sv ====
`timescale 1ns/100ps

module soc_fabric_checker
(
     input logic                                 clk_i
    ,input logic                                 rst_n_i
    ,input logic                                 awready_i
    ,input logic                                 wready_i
    ,input logic                                 arready_i
    ,input logic                                 bvalid_i
    ,input logic                                 bready_i
    ,input logic [1:0]                           bresp_i
    ,input logic                                 rvalid_i
    ,input logic                                 rready_i
    ,input logic [soc_fabric_pkg::DATA_W-1:0]    rdata_i
    ,input logic [1:0]                           rresp_i
);

// B and R hold until taken
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("B response dropped or changed before bready");

assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else $error("R response dropped or changed before rready");

assert property (@(posedge clk_i) awready_i == wready_i)
    else $error("awready and wready differ");

// Checked from the second reset cycle on, once state is cleared
assert property (@(posedge clk_i)
    !rst_n_i && !$past(rst_n_i) |->
        !(awready_i || arready_i || (bvalid_i && bready_i) || (rvalid_i && rready_i)))
    else $error("Handshake seen during reset");

endmodule

// ==== verif/soc_fabric_tb.sv ====
`timescale 1ns/100ps

module soc_fabric_tb;

// About 67 transactions of 20 cycles or less each, plus margin
localparam int          TIMEOUT_CYCLES = 2000;
localparam logic [31:0] RAM_BASE  = soc_fabric_pkg::RAM_BASE;
localparam logic [31:0] GPIO_BASE = soc_fabric_pkg::GPIO_BASE;
localparam logic [31:0] ADDR_OUT  = GPIO_BASE | {28'h0, soc_fabric_pkg::REG_GPIO_OUT};
localparam logic [31:0] ADDR_OE   = GPIO_BASE | {28'h0, soc_fabric_pkg::REG_GPIO_OE};
localparam logic [31:0] ADDR_IN   = GPIO_BASE | {28'h0, soc_fabric_pkg::REG_GPIO_IN};
localparam logic [31:0] ADDR_CTRL = GPIO_BASE | {28'h0, soc_fabric_pkg::REG_CTRL};
localparam logic [1:0]  OKAY      = soc_fabric_pkg::RESP_OKAY;
localparam logic [1:0]  SLVERR    = soc_fabric_pkg::RESP_SLVERR;

logic        clk;
logic        rst_n;
logic        awvalid;
logic [31:0] awaddr;
logic        awready;
logic        wvalid;
logic [31:0] wdata;
logic [3:0]  wstrb;
logic        wready;
logic        bvalid;
logic [1:0]  bresp;
logic        bready;
logic        arvalid;
logic [31:0] araddr;
logic        arready;
logic        rvalid;
logic [31:0] rdata;
logic [1:0]  rresp;
logic        rready;
logic [31:0] gpio_in;
logic [31:0] gpio_out;
logic [31:0] gpio_oe;
logic        rst_cpu;

int          cycle_count;
int          error_count;
integer      seed;
logic [31:0] ram_addr [16];
logic [31:0] ram_data [16];

soc_fabric_top
#(
     .FIFO_DEPTH(4)
    ,.RAM_WORDS(256)
)
DUT
(
     .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.s_awvalid_i(awvalid)
    ,.s_awaddr_i(awaddr)
    ,.s_awready_o(awready)
    ,.s_wvalid_i(wvalid)
    ,.s_wdata_i(wdata)
    ,.s_wstrb_i(wstrb)
    ,.s_wready_o(wready)
    ,.s_bvalid_o(bvalid)
    ,.s_bresp_o(bresp)
    ,.s_bready_i(bready)
    ,.s_arvalid_i(arvalid)
    ,.s_araddr_i(araddr)
    ,.s_arready_o(arready)
    ,.s_rvalid_o(rvalid)
    ,.s_rdata_o(rdata)
    ,.s_rresp_o(rresp)
    ,.s_rready_i(rready)
    ,.gpio_input_i(gpio_in)
    ,.gpio_output_o(gpio_out)
    ,.gpio_output_enable_o(gpio_oe)
    ,.rst_cpu_o(rst_cpu)
);

bind soc_fabric_top soc_fabric_checker u_checker
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.awready_i(s_awready_o)
    ,.wready_i(s_wready_o)
    ,.arready_i(s_arready_o)
    ,.bvalid_i(s_bvalid_o)
    ,.bready_i(s_bready_i)
    ,.bresp_i(s_bresp_o)
    ,.rvalid_i(s_rvalid_o)
    ,.rready_i(s_rready_i)
    ,.rdata_i(s_rdata_o)
    ,.rresp_i(s_rresp_o)
);

always #5 clk = ~clk;

always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped by the cycle limit");
    end
end

//----------------------------------------------------------------------
// Bus tasks
//----------------------------------------------------------------------
task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
        error_count = error_count + 1;
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first mismatch");
    end
endtask

// Leaves the write accepted but does not wait for B
task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    @(posedge clk);
    while (!awready) @(posedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
endtask

task automatic axil_write(input string name, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          input logic [1:0] exp_resp);
    issue_write(addr, data, strb);
    @(posedge clk);
    while (!bvalid) @(posedge clk);
    compare_value({name, " bresp"}, 32'(exp_resp), 32'(bresp));
endtask

task automatic axil_read(input string name, input logic [31:0] addr,
                         input logic [31:0] exp_data, input logic [1:0] exp_resp);
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    @(posedge clk);
    while (!arready) @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    compare_value({name, " rresp"}, 32'(exp_resp), 32'(rresp));
    compare_value({name, " rdata"}, exp_data, rdata);
endtask

//----------------------------------------------------------------------
// Directed tests
//----------------------------------------------------------------------
task automatic reset_values_test();
    compare_value("reset rst_cpu", 32'd1, 32'(rst_cpu));
    compare_value("reset gpio_out", 32'd0, gpio_out);
    compare_value("reset gpio_oe", 32'd0, gpio_oe);
    axil_read("reset GPIO_OUT", ADDR_OUT, 32'd0, OKAY);
    axil_read("reset GPIO_OE", ADDR_OE, 32'd0, OKAY);
    axil_read("reset CTRL", ADDR_CTRL, 32'd0, OKAY);
endtask

task automatic ram_access_test();
    logic [31:0] idx;
    // Upper nibble of the index keeps the sixteen words distinct
    for (int i = 0; i < 16; i++) begin
        idx = {24'd0, 4'(i), 4'($random(seed))};
        ram_addr[i] = RAM_BASE + (idx << 2);
        ram_data[i] = $random(seed);
        axil_write("ram write", ram_addr[i], ram_data[i], 4'hF, OKAY);
    end
    for (int i = 0; i < 16; i++) begin
        axil_read("ram readback", ram_addr[i], ram_data[i], OKAY);
    end
    axil_write("ram full word", RAM_BASE + 32'h3F0, 32'h1122_3344, 4'hF, OKAY);
    axil_write("ram partial", RAM_BASE + 32'h3F0, 32'hAABB_CCDD, 4'b0101, OKAY);
    axil_read("ram partial", RAM_BASE + 32'h3F0, 32'h11BB_33DD, OKAY);
    // Word 508 lands on word 252
    axil_read("ram wrap", RAM_BASE + 32'h7F0, 32'h11BB_33DD, OKAY);
endtask

task automatic gpio_output_test();
    axil_write("gpio out write", ADDR_OUT, 32'hA5A5_0F0F, 4'hF, OKAY);
    axil_write("gpio oe write", ADDR_OE, 32'hFFFF_0000, 4'hF, OKAY);
    @(negedge clk);
    compare_value("gpio out pins", 32'hA5A5_0F0F, gpio_out);
    compare_value("gpio oe pins", 32'hFFFF_0000, gpio_oe);
    axil_read("gpio out read", ADDR_OUT, 32'hA5A5_0F0F, OKAY);
    axil_read("gpio oe read", ADDR_OE, 32'hFFFF_0000, OKAY);
    axil_write("gpio out byte", ADDR_OUT, 32'h0000_00FF, 4'b0001, OKAY);
    axil_read("gpio out byte", ADDR_OUT, 32'hA5A5_0FFF, OKAY);
    axil_write("ctrl set", ADDR_CTRL, 32'h1, 4'hF, OKAY);
    @(negedge clk);
    compare_value("ctrl set rst_cpu", 32'd0, 32'(rst_cpu));
    axil_read("ctrl read", ADDR_CTRL, 32'h1, OKAY);
    axil_write("ctrl clear", ADDR_CTRL, 32'h0, 4'hF, OKAY);
    @(negedge clk);
    compare_value("ctrl clear rst_cpu", 32'd1, 32'(rst_cpu));
endtask

task automatic gpio_input_test();
    @(negedge clk);
    gpio_in = 32'h1357_9BDF;
    repeat (4) @(negedge clk);
    axil_read("gpio in read", ADDR_IN, 32'h1357_9BDF, OKAY);
    axil_write("gpio in write", ADDR_IN, 32'hFFFF_FFFF, 4'hF, OKAY);
    axil_read("gpio in after write", ADDR_IN, 32'h1357_9BDF, OKAY);
endtask

task automatic unmapped_test();
    axil_write("unmapped write", 32'h1000_0000, 32'hDEAD_BEEF, 4'hF, SLVERR);
    axil_read("unmapped read", 32'h1000_0000, 32'h0, SLVERR);
    // R stays up while rready is low
    @(negedge clk);
    rready = 1'b0;
    axil_read("unmapped read held", 32'h1000_0000, 32'h0, SLVERR);
    repeat (2) @(posedge clk);
    compare_value("unmapped rvalid held", 32'd1, 32'(rvalid));
    @(negedge clk);
    rready = 1'b1;
endtask

task automatic backpressure_test();
    logic [31:0] base;
    logic        sixth_taken;
    int          bresp_count;
    base = RAM_BASE + 32'h200;
    @(negedge clk);
    bready = 1'b0;
    // One held in the target, four in the FIFO
    for (int i = 0; i < 5; i++) begin
        issue_write(base + 32'(i * 4), 32'hB0B0_0000 | 32'(i), 4'hF);
    end
    awvalid = 1'b1;
    awaddr  = base + 32'h14;
    wvalid  = 1'b1;
    wdata   = 32'hB0B0_0005;
    wstrb   = 4'hF;
    repeat (4) begin
        @(posedge clk);
        compare_value("backpressure awready", 32'd0, 32'(awready));
    end
    @(negedge clk);
    bready      = 1'b1;
    sixth_taken = 1'b0;
    bresp_count = 0;
    while (bresp_count < 6) begin
        @(posedge clk);
        if (awready) begin
            sixth_taken = 1'b1;
        end
        if (bvalid) begin
            compare_value("backpressure bresp", 32'(OKAY), 32'(bresp));
            bresp_count++;
        end
        @(negedge clk);
        if (sixth_taken) begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
    end
    for (int i = 0; i < 6; i++) begin
        axil_read("backpressure readback", base + 32'(i * 4), 32'hB0B0_0000 | 32'(i), OKAY);
    end
endtask

initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b1;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b1;
    gpio_in     = '0;
    cycle_count = 0;
    error_count = 0;
    seed        = 20116;
    @(posedge clk);
    // Traffic offered while reset is still held
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    rst_n   = 1'b1;

    reset_values_test();
    ram_access_test();
    gpio_output_test();
    gpio_input_test();
    unmapped_test();
    backpressure_test();

    @(negedge clk);
    if (error_count == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule
